/* design/soc_ctrl_pkg.sv */
package soc_ctrl_pkg;

	// --------------------------------------------------
	// Wishbone side
	// --------------------------------------------------
	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [3:0]  wb_sel_t;

	// Request as held by the master until ack
	typedef struct packed {
		wb_addr_t adr;
		wb_data_t dat_w;
		wb_sel_t  sel;
		logic     we;
	} wb_req_t;

	typedef struct packed {
		wb_data_t dat_r;
		logic     ack;
		logic     err;
	} wb_rsp_t;

	// --------------------------------------------------
	// CSR side
	// --------------------------------------------------
	// Word address, top 4 bits bank and low 10 bits register
	typedef logic [13:0] csr_addr_t;
	typedef logic [31:0] csr_data_t;

	typedef struct packed {
		csr_addr_t a;
		logic      we;
		csr_data_t dw;
	} csr_req_t;

	// Address bits 30:28, bit 31 is a shadow of the same map
	typedef enum logic [2:0] {
		REGION_FLASH = 3'b000,
		REGION_DEBUG = 3'b001,
		REGION_USB   = 3'b010,
		REGION_ETH   = 3'b011,
		REGION_SDRAM = 3'b100,
		REGION_CSR   = 3'b110
	} region_t;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT,
		DONE
	} bridge_state_t;

	localparam logic [3:0] SYSCTL_BANK = 4'd1;

	// System controller register map
	localparam logic [9:0] REG_GPIO_IN     = 10'd0;
	localparam logic [9:0] REG_GPIO_OUT    = 10'd1;
	localparam logic [9:0] REG_GPIO_IRQ_EN = 10'd2;
	localparam logic [9:0] REG_BUS_ERR_EN  = 10'd3;
	localparam logic [9:0] REG_SYSTEM_ID   = 10'd4;
	localparam logic [9:0] REG_HARD_RESET  = 10'd5;

	// Locked area is the low 256 KiB
	localparam int LOCKED_ADDR_BITS = 14;

	// pcb_revision[3:0], btn3, btn2, btn1
	localparam int N_GPIO_IN  = 7;
	localparam int N_GPIO_OUT = 2;

endpackage

/* design/reset_sequencer.sv */
`timescale 1ns/1ps

module reset_sequencer #(
	parameter int RESET_DEBOUNCE_WIDTH = 20,
	parameter int FLASH_RESET_WIDTH    = 8
) (
	input  logic       sys_clk,
	input  logic       trigger_reset,
	input  logic [2:0] btn_i,
	input  logic       hard_reset_i,
	output logic       sys_rst_o,
	output logic       flash_rst_n_o,
	output logic       periph_rst_n_o
);

	logic                            rst_req_q;
	logic [RESET_DEBOUNCE_WIDTH-1:0] debounce_q;
	logic                            sys_rst_q;
	logic [FLASH_RESET_WIDTH-1:0]    flash_cnt_q;

	// Any of the three sources restarts the whole sequence
	always_ff @(posedge sys_clk) begin
		if (trigger_reset)
			rst_req_q <= 1'b1;
		else
			rst_req_q <= (&btn_i) | hard_reset_i;
	end

	// --------------------------------------------------
	// Debounce counter, holds sys_rst until it drains
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_req_q)
			debounce_q <= '1;
		else if (debounce_q != '0)
			debounce_q <= debounce_q - 1'b1;
		// Enter reset on the same edge that clears the flash counter
		sys_rst_q <= rst_req_q | (debounce_q != '0);
	end

	// Flash leaves reset well before the system does
	always_ff @(posedge sys_clk) begin
		if (rst_req_q)
			flash_cnt_q <= '0;
		else if (!flash_cnt_q[FLASH_RESET_WIDTH-1])
			flash_cnt_q <= flash_cnt_q + 1'b1;
	end

	assign sys_rst_o      = sys_rst_q;
	assign flash_rst_n_o  = flash_cnt_q[FLASH_RESET_WIDTH-1];
	assign periph_rst_n_o = ~sys_rst_q;

	// First fetch after reset goes to flash, so it must already be out of reset
	assert property (@(posedge sys_clk) $fell(sys_rst_q) |-> flash_rst_n_o)
		else $error("sys_rst released while flash still in reset");

endmodule

/* design/wb_decoder.sv */
`timescale 1ns/1ps

module wb_decoder import soc_ctrl_pkg::*; (
	input  logic      sys_clk,
	input  logic      sys_rst_i,
	input  wb_req_t   wb_req_i,
	input  logic      wb_cyc_i,
	input  logic      wb_stb_i,
	input  logic      bus_err_en_i,
	input  logic      csr_done_i,
	input  csr_data_t csr_dat_i,
	output logic      csr_valid_o,
	output wb_req_t   csr_wb_o,
	output wb_rsp_t   wb_rsp_o
);

	logic    busy_q;
	logic    stub_ack_q;
	wb_req_t req_q;
	region_t region_q;
	logic    locked_q;
	logic    ack;
	logic    accept;

	// Bit 31 is not looked at, upper half mirrors the lower
	function automatic region_t decode_region(input wb_addr_t adr);
		casez (adr[30:28])
			3'b000:  return REGION_FLASH;
			3'b001:  return REGION_DEBUG;
			3'b010:  return REGION_USB;
			3'b011:  return REGION_ETH;
			3'b10?:  return REGION_SDRAM;
			default: return REGION_CSR;
		endcase
	endfunction

	assign ack    = stub_ack_q | csr_done_i;
	assign accept = wb_cyc_i & wb_stb_i & ~busy_q & ~ack;

	// --------------------------------------------------
	// Request capture
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			req_q    <= wb_req_i;
			region_q <= decode_region(wb_req_i.adr);
			locked_q <= (wb_req_i.adr[31 -: LOCKED_ADDR_BITS] == '0);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			busy_q     <= 1'b0;
			stub_ack_q <= 1'b0;
		end else begin
			stub_ack_q <= 1'b0;
			if (accept)
				busy_q <= 1'b1;
			else if (busy_q && ack)
				busy_q <= 1'b0;
			else if (busy_q && region_q != REGION_CSR)
				// No slave behind these regions, answer right away
				stub_ack_q <= 1'b1;
		end
	end

	assign csr_valid_o = busy_q && (region_q == REGION_CSR);
	assign csr_wb_o    = req_q;

	// Stub regions read as zero
	assign wb_rsp_o.dat_r = csr_done_i ? csr_dat_i : '0;
	assign wb_rsp_o.ack   = ack;
	assign wb_rsp_o.err   = ack & bus_err_en_i & locked_q;

	assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_rsp_o.ack |=> !wb_rsp_o.ack)
		else $error("Wishbone ack held for more than one cycle");

endmodule

/* design/csr_bridge.sv */
`timescale 1ns/1ps

module csr_bridge import soc_ctrl_pkg::*; (
	input  logic      sys_clk,
	input  logic      sys_rst_i,
	input  logic      csr_valid_i,
	input  wb_req_t   csr_wb_i,
	input  csr_data_t csr_rdata_i,
	output csr_req_t  csr_o,
	output logic      csr_done_o,
	output csr_data_t csr_dat_o
);

	bridge_state_t state_q;
	bridge_state_t state_d;
	csr_data_t     rdata_q;

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (csr_valid_i)
					state_d = ISSUE;
			end
			ISSUE:   state_d = WAIT;
			// Slave registers its read data during this cycle
			WAIT:    state_d = DONE;
			DONE:    state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	// Capture the slave word on the way into DONE
	always_ff @(posedge sys_clk) begin
		if (state_q == WAIT)
			rdata_q <= csr_rdata_i;
	end

	// Word address from byte address bits 15:2
	assign csr_o.a  = csr_wb_i.adr[15:2];
	assign csr_o.dw = csr_wb_i.dat_w;
	assign csr_o.we = (state_q == ISSUE) & csr_wb_i.we;

	assign csr_done_o = (state_q == DONE);
	assign csr_dat_o  = rdata_q;

	// A write strobe only follows a fresh request out of IDLE
	assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		csr_o.we |-> state_q == ISSUE && $past(state_q) == IDLE && csr_valid_i)
		else $error("CSR write strobe outside ISSUE");

endmodule

/* design/sysctl_regs.sv */
`timescale 1ns/1ps

module sysctl_regs import soc_ctrl_pkg::*; #(
	parameter csr_data_t SYSTEM_ID = 32'h13004D31
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst_i,
	input  csr_req_t              csr_i,
	output csr_data_t             csr_o,
	input  logic [N_GPIO_IN-1:0]  gpio_in_i,
	output logic [N_GPIO_OUT-1:0] gpio_out_o,
	output logic                  gpio_irq_o,
	output logic                  bus_err_en_o,
	output logic                  hard_reset_o
);

	logic [N_GPIO_IN-1:0]  gpio_meta_q;
	logic [N_GPIO_IN-1:0]  gpio_sync_q;
	logic [N_GPIO_IN-1:0]  gpio_prev_q;
	logic [N_GPIO_OUT-1:0] gpio_out_q;
	logic                  irq_en_q;
	logic                  irq_q;
	logic                  bus_err_en_q;
	logic                  hard_reset_q;
	csr_data_t             rdata_q;
	logic                  bank_hit;
	logic [9:0]            reg_idx;
	logic                  wr;

	assign bank_hit = (csr_i.a[13:10] == SYSCTL_BANK);
	assign reg_idx  = csr_i.a[9:0];
	assign wr       = bank_hit & csr_i.we;

	// --------------------------------------------------
	// Input synchroniser and change detect
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_meta_q <= gpio_in_i;
		gpio_sync_q <= gpio_meta_q;
		gpio_prev_q <= gpio_sync_q;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			irq_q <= 1'b0;
		else
			irq_q <= irq_en_q && (gpio_sync_q != gpio_prev_q);
	end

	// --------------------------------------------------
	// Writable registers
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_q   <= '0;
			irq_en_q     <= 1'b0;
			bus_err_en_q <= 1'b0;
			hard_reset_q <= 1'b0;
		end else begin
			// Write of any value restarts the board
			hard_reset_q <= wr && (reg_idx == REG_HARD_RESET);
			if (wr) begin
				case (reg_idx)
					REG_GPIO_OUT:    gpio_out_q   <= csr_i.dw[N_GPIO_OUT-1:0];
					REG_GPIO_IRQ_EN: irq_en_q     <= csr_i.dw[0];
					REG_BUS_ERR_EN:  bus_err_en_q <= csr_i.dw[0];
					default: ;
				endcase
			end
		end
	end

	// Read data follows the address every cycle
	always_ff @(posedge sys_clk) begin
		if (!bank_hit) begin
			rdata_q <= '0;
		end else begin
			case (reg_idx)
				REG_GPIO_IN:     rdata_q <= csr_data_t'(gpio_sync_q);
				REG_GPIO_OUT:    rdata_q <= csr_data_t'(gpio_out_q);
				REG_GPIO_IRQ_EN: rdata_q <= csr_data_t'(irq_en_q);
				REG_BUS_ERR_EN:  rdata_q <= csr_data_t'(bus_err_en_q);
				REG_SYSTEM_ID:   rdata_q <= SYSTEM_ID;
				default:         rdata_q <= '0;
			endcase
		end
	end

	assign csr_o        = rdata_q;
	assign gpio_out_o   = gpio_out_q;
	assign gpio_irq_o   = irq_q;
	assign bus_err_en_o = bus_err_en_q;
	assign hard_reset_o = hard_reset_q;

endmodule

/* design/soc_ctrl_top.sv */
`timescale 1ns/1ps

module soc_ctrl_top import soc_ctrl_pkg::*; #(
	parameter int        RESET_DEBOUNCE_WIDTH = 20,
	parameter int        FLASH_RESET_WIDTH    = 8,
	parameter csr_data_t SYSTEM_ID            = 32'h13004D31
) (
	input  logic                  sys_clk,
	input  logic                  trigger_reset,
	input  wb_req_t               wb_req_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic [2:0]            btn_i,
	input  logic [3:0]            pcb_revision_i,
	output wb_rsp_t               wb_rsp_o,
	output logic [N_GPIO_OUT-1:0] led_o,
	output logic                  gpio_irq_o,
	output logic                  flash_rst_n_o,
	output logic                  periph_rst_n_o
);

	logic      sys_rst;
	logic      hard_reset;
	logic      bus_err_en;
	logic      csr_valid;
	wb_req_t   csr_wb;
	logic      csr_done;
	csr_data_t csr_dat;
	csr_req_t  csr_req;
	csr_data_t csr_rdata;

	// --------------------------------------------------
	// Reset generation
	// --------------------------------------------------
	reset_sequencer #(
		.RESET_DEBOUNCE_WIDTH(RESET_DEBOUNCE_WIDTH),
		.FLASH_RESET_WIDTH(FLASH_RESET_WIDTH)
	) reset_sequencer_inst (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.btn_i(btn_i),
		.hard_reset_i(hard_reset),
		.sys_rst_o(sys_rst),
		.flash_rst_n_o(flash_rst_n_o),
		.periph_rst_n_o(periph_rst_n_o)
	);

	// --------------------------------------------------
	// Bus path
	// --------------------------------------------------
	wb_decoder wb_decoder_inst (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.wb_req_i(wb_req_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.bus_err_en_i(bus_err_en),
		.csr_done_i(csr_done),
		.csr_dat_i(csr_dat),
		.csr_valid_o(csr_valid),
		.csr_wb_o(csr_wb),
		.wb_rsp_o(wb_rsp_o)
	);

	csr_bridge csr_bridge_inst (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_valid_i(csr_valid),
		.csr_wb_i(csr_wb),
		.csr_rdata_i(csr_rdata),
		.csr_o(csr_req),
		.csr_done_o(csr_done),
		.csr_dat_o(csr_dat)
	);

	// Inputs packed as pcb revision over the buttons
	sysctl_regs #(
		.SYSTEM_ID(SYSTEM_ID)
	) sysctl_regs_inst (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_i(csr_req),
		.csr_o(csr_rdata),
		.gpio_in_i({pcb_revision_i, btn_i}),
		.gpio_out_o(led_o),
		.gpio_irq_o(gpio_irq_o),
		.bus_err_en_o(bus_err_en),
		.hard_reset_o(hard_reset)
	);

endmodule

/* tests/tb_soc_ctrl.sv */
`timescale 1ns/1ps

module tb_soc_ctrl import soc_ctrl_pkg::*; ();

	localparam int DEBOUNCE_W      = 6;
	localparam int FLASH_W         = 4;
	localparam int RESET_CYCLES    = 2 ** DEBOUNCE_W;
	localparam int RESET_EVENTS    = 3;
	localparam int N_TRANSACTIONS  = 19;
	localparam int WATCHDOG_CYCLES = RESET_EVENTS * RESET_CYCLES + N_TRANSACTIONS * 10 + 200;
	// Cycles from the accepting edge up to the cycle that shows ack
	localparam int STUB_ACK_CYCLES = 2;
	localparam int CSR_ACK_CYCLES  = 4;
	localparam int ACK_LIMIT       = 20;

	localparam wb_addr_t ADDR_GPIO_IN    = 32'h6000_1000;
	localparam wb_addr_t ADDR_GPIO_OUT   = 32'h6000_1004;
	localparam wb_addr_t ADDR_IRQ_EN     = 32'h6000_1008;
	localparam wb_addr_t ADDR_BUS_ERR_EN = 32'h6000_100C;
	localparam wb_addr_t ADDR_SYSTEM_ID  = 32'h6000_1010;
	localparam wb_addr_t ADDR_HARD_RESET = 32'h6000_1014;
	localparam logic [31:0] EXP_SYSTEM_ID = 32'h1300_4D31;

	logic                  sys_clk;
	logic                  trigger_reset;
	wb_req_t               wb_req;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic [2:0]            btn;
	logic [3:0]            pcb_revision;
	wb_rsp_t               wb_rsp;
	logic [N_GPIO_OUT-1:0] led;
	logic                  gpio_irq;
	logic                  flash_rst_n;
	logic                  periph_rst_n;

	logic     arm;
	integer   seed;
	int       errors;
	int       checks;
	int       transactions;
	logic     rsp_seen;
	wb_data_t rsp_data;
	logic     rsp_err;
	int       rsp_cycles;

	soc_ctrl_top #(
		.RESET_DEBOUNCE_WIDTH(DEBOUNCE_W),
		.FLASH_RESET_WIDTH(FLASH_W)
	) soc_ctrl_top_inst (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_req_i(wb_req),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.btn_i(btn),
		.pcb_revision_i(pcb_revision),
		.wb_rsp_o(wb_rsp),
		.led_o(led),
		.gpio_irq_o(gpio_irq),
		.flash_rst_n_o(flash_rst_n),
		.periph_rst_n_o(periph_rst_n)
	);

	always #2 sys_clk = ~sys_clk;

	// --------------------------------------------------
	// Protocol and reset properties
	// --------------------------------------------------
	assert property (@(posedge sys_clk) disable iff (!arm)
		$rose(periph_rst_n) |-> $past(flash_rst_n))
		else begin
			errors++;
			$display("peripherals left reset before flash did");
		end

	assert property (@(posedge sys_clk) disable iff (!arm)
		periph_rst_n |-> flash_rst_n)
		else begin
			errors++;
			$display("periph_rst_n_o high while flash_rst_n_o is low");
		end

	assert property (@(posedge sys_clk) disable iff (!arm)
		wb_rsp.ack |=> !wb_rsp.ack)
		else begin
			errors++;
			$display("ack stayed high for more than one cycle");
		end

	assert property (@(posedge sys_clk) disable iff (!arm)
		wb_rsp.err |-> wb_rsp.ack)
		else begin
			errors++;
			$display("err raised without ack");
		end

	assert property (@(posedge sys_clk) disable iff (!arm)
		gpio_irq |=> !gpio_irq)
		else begin
			errors++;
			$display("gpio_irq_o pulse longer than one cycle");
		end

	// Outputs settle low one cycle into the reset
	assert property (@(posedge sys_clk) disable iff (!arm)
		!periph_rst_n && $past(!periph_rst_n) |->
			!wb_rsp.ack && !wb_rsp.err && led == '0 && !gpio_irq)
		else begin
			errors++;
			$display("bus or GPIO outputs active during reset");
		end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("mismatch %s expected 0x%h actual 0x%h", name, expected, actual);
		end
	endtask

	// --------------------------------------------------
	// Bus master
	// --------------------------------------------------
	task automatic bus_cycle(input wb_addr_t adr, input logic we, input wb_data_t dat);
		int n;
		n = 0;
		wb_req.adr   = adr;
		wb_req.dat_w = dat;
		wb_req.sel   = 4'hF;
		wb_req.we    = we;
		wb_cyc       = 1'b1;
		wb_stb       = 1'b1;
		rsp_seen     = 1'b0;
		while (!rsp_seen && n < ACK_LIMIT) begin
			@(negedge sys_clk);
			n++;
			if (wb_rsp.ack) begin
				rsp_seen = 1'b1;
				rsp_data = wb_rsp.dat_r;
				rsp_err  = wb_rsp.err;
			end
		end
		// First negedge comes before the accepting edge
		rsp_cycles = n - 1;
		transactions++;
		checks++;
		assert (rsp_seen) else begin
			errors++;
			$display("no ack for access to address 0x%h", adr);
		end
		@(posedge sys_clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_req = '0;
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
		bus_cycle(adr, 1'b1, dat);
	endtask

	task automatic wb_read(input wb_addr_t adr);
		bus_cycle(adr, 1'b0, '0);
	endtask

	task automatic check_ack(input logic expected_err, input int expected_cycles);
		check_value("wb_rsp_o.err", 32'(expected_err), 32'(rsp_err));
		check_value("ack latency", 32'(expected_cycles), 32'(rsp_cycles));
	endtask

	task automatic count_irq_pulses(input int window, output int pulses);
		pulses = 0;
		repeat (window) begin
			@(negedge sys_clk);
			if (gpio_irq)
				pulses++;
		end
		@(posedge sys_clk);
		#1;
	endtask

	// --------------------------------------------------
	// Reset sequence
	// --------------------------------------------------
	task automatic wait_reset_entry();
		int n;
		n = 0;
		while (periph_rst_n && n < 16) begin
			@(negedge sys_clk);
			n++;
		end
		checks++;
		assert (!periph_rst_n) else begin
			errors++;
			$display("reset request did not pull periph_rst_n_o low");
		end
		check_value("flash_rst_n_o", 32'h0, 32'(flash_rst_n));
	endtask

	task automatic measure_release();
		int n;
		n = 0;
		while (!periph_rst_n && n < 4 * RESET_CYCLES) begin
			@(negedge sys_clk);
			n++;
		end
		checks++;
		assert (n >= RESET_CYCLES - 4 && n <= RESET_CYCLES + 8) else begin
			errors++;
			$display("periph_rst_n_o released after %0d cycles, expected about %0d",
				n, RESET_CYCLES);
		end
		@(posedge sys_clk);
		#1;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("timeout after %0d cycles, test sequence did not finish", WATCHDOG_CYCLES);
		$display("summary: %0d checks, %0d errors, %0d transactions",
			checks, errors, transactions);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		wb_data_t value;
		int       pulses;
		seed          = 67;
		errors        = 0;
		checks        = 0;
		transactions  = 0;
		arm           = 1'b0;
		sys_clk       = 1'b0;
		trigger_reset = 1'b1;
		wb_req        = '0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		btn           = 3'b010;
		value         = $random(seed);
		pcb_revision  = value[3:0];

		repeat (8) @(posedge sys_clk);
		#1;
		wait_reset_entry();
		trigger_reset = 1'b0;
		arm           = 1'b1;
		measure_release();

		// Stub regions, bit 31 mirrors the map
		wb_read(32'h2000_0100);
		check_ack(1'b0, STUB_ACK_CYCLES);
		check_value("wb_rsp_o.dat_r", 32'h0, rsp_data);
		wb_read(32'h0000_0100);
		check_ack(1'b0, STUB_ACK_CYCLES);
		check_value("wb_rsp_o.dat_r", 32'h0, rsp_data);
		wb_read(32'hA000_0100);
		check_ack(1'b0, STUB_ACK_CYCLES);
		check_value("wb_rsp_o.dat_r", 32'h0, rsp_data);

		// LEDs and system ID
		value = $random(seed);
		wb_write(ADDR_GPIO_OUT, value);
		check_ack(1'b0, CSR_ACK_CYCLES);
		check_value("led_o", 32'(value[1:0]), 32'(led));
		wb_read(ADDR_GPIO_OUT);
		check_ack(1'b0, CSR_ACK_CYCLES);
		check_value("wb_rsp_o.dat_r", 32'(value[1:0]), rsp_data);
		wb_read(ADDR_SYSTEM_ID);
		check_ack(1'b0, CSR_ACK_CYCLES);
		check_value("wb_rsp_o.dat_r", EXP_SYSTEM_ID, rsp_data);

		// GPIO inputs and change interrupt
		wb_read(ADDR_GPIO_IN);
		check_ack(1'b0, CSR_ACK_CYCLES);
		check_value("wb_rsp_o.dat_r", 32'({pcb_revision, btn}), rsp_data);
		wb_write(ADDR_IRQ_EN, 32'h1);
		check_ack(1'b0, CSR_ACK_CYCLES);
		btn = 3'b011;
		count_irq_pulses(4, pulses);
		check_value("gpio_irq_o pulses", 32'h1, 32'(pulses));
		wb_write(ADDR_IRQ_EN, 32'h0);
		check_ack(1'b0, CSR_ACK_CYCLES);
		btn = 3'b010;
		count_irq_pulses(8, pulses);
		check_value("gpio_irq_o pulses", 32'h0, 32'(pulses));

		// Locked low area only errs while enabled
		wb_write(ADDR_BUS_ERR_EN, 32'h1);
		check_ack(1'b0, CSR_ACK_CYCLES);
		wb_read(32'h0000_0100);
		check_ack(1'b1, STUB_ACK_CYCLES);
		check_value("wb_rsp_o.dat_r", 32'h0, rsp_data);
		wb_read(32'h0004_0000);
		check_ack(1'b0, STUB_ACK_CYCLES);
		wb_read(ADDR_SYSTEM_ID);
		check_ack(1'b0, CSR_ACK_CYCLES);
		check_value("wb_rsp_o.dat_r", EXP_SYSTEM_ID, rsp_data);

		// --------------------------------------------------
		// Restart by register, then by button chord
		// --------------------------------------------------
		wb_write(ADDR_GPIO_OUT, 32'h3);
		check_ack(1'b0, CSR_ACK_CYCLES);
		value = $random(seed);
		wb_write(ADDR_HARD_RESET, value);
		check_ack(1'b0, CSR_ACK_CYCLES);
		wait_reset_entry();
		measure_release();
		check_value("led_o", 32'h0, 32'(led));
		wb_read(ADDR_BUS_ERR_EN);
		check_ack(1'b0, CSR_ACK_CYCLES);
		check_value("wb_rsp_o.dat_r", 32'h0, rsp_data);

		wb_write(ADDR_GPIO_OUT, 32'h3);
		check_ack(1'b0, CSR_ACK_CYCLES);
		wb_write(ADDR_BUS_ERR_EN, 32'h1);
		check_ack(1'b0, CSR_ACK_CYCLES);
		btn = 3'b111;
		wait_reset_entry();
		@(posedge sys_clk);
		#1;
		btn = 3'b010;
		measure_release();
		check_value("led_o", 32'h0, 32'(led));
		wb_read(ADDR_BUS_ERR_EN);
		check_ack(1'b0, CSR_ACK_CYCLES);
		check_value("wb_rsp_o.dat_r", 32'h0, rsp_data);

		$display("summary: %0d checks, %0d errors, %0d transactions",
			checks, errors, transactions);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* list.f */
design/soc_ctrl_pkg.sv
design/reset_sequencer.sv
design/wb_decoder.sv
design/csr_bridge.sv
design/sysctl_regs.sv
design/soc_ctrl_top.sv
tests/tb_soc_ctrl.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_soc_ctrl -f list.f -o tb_soc_ctrl
./obj_dir/tb_soc_ctrl | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "run_sim: simulation passed"
else
	echo "run_sim: simulation failed, see sim.log"
	exit 1
fi
